//--- source/frame_ring_pkg.sv
/*
 * Shared widths and types for the frame ring release subsystem.
 * A line address is the ring base, the frame index and the chunk offset
 */
package frame_ring_pkg;

   // Number of frame rings served by the subsystem
   localparam int NUM_CHANNELS = 4;
   localparam int LOG_NUM_CHANNELS = 2;

   // Each ring holds 16 frames of 8 lines each
   localparam int LOG_FRAME_NUMBER = 4;
   localparam int LOG_FRAME_CHUNKS = 3;

   // The base pointer takes the address bits left over above frame and chunk
   localparam int LOG_FRAME_BASE_POINTER = 25;
   localparam int MEM_ADDRESS_WIDTH =
      LOG_FRAME_BASE_POINTER + LOG_FRAME_NUMBER + LOG_FRAME_CHUNKS;

   localparam int LINE_DATA_WIDTH = 64;

   // One extra bit so a full ring of 16 outstanding releases can be counted
   localparam int PENDING_WIDTH = LOG_FRAME_NUMBER + 1;

   typedef logic [LOG_NUM_CHANNELS-1:0]       channel_t;
   typedef logic [LOG_FRAME_NUMBER-1:0]       frame_number_t;
   typedef logic [LOG_FRAME_BASE_POINTER-1:0] frame_base_pointer_t;
   typedef logic [PENDING_WIDTH-1:0]          pending_t;
   typedef logic [MEM_ADDRESS_WIDTH-1:0]      mem_address_t;
   typedef logic [LINE_DATA_WIDTH-1:0]        line_data_t;

   // Header line that hands a frame back to the producer
   // Only the low empty bit is set
   localparam line_data_t RELEASE_LINE = line_data_t'(1);

endpackage

//--- source/release_config.sv
/*
 * Release configuration block. Holds one ring base pointer per channel
 * and turns the release strobe into a registered per-channel pulse
 */
`timescale 1ns/10ps

module release_config (
   input  logic                                   clk,
   input  logic                                   resetb,
   input  logic                                   cfg_write,
   input  frame_ring_pkg::channel_t               cfg_channel,
   input  frame_ring_pkg::frame_base_pointer_t    cfg_base_pointer,
   input  logic                                   release_valid,
   input  frame_ring_pkg::channel_t               release_channel,
   output logic [frame_ring_pkg::NUM_CHANNELS-1:0] release_frame,
   output frame_ring_pkg::frame_base_pointer_t [frame_ring_pkg::NUM_CHANNELS-1:0] base_pointer
);

   // One-hot decode of the release channel, before the output register
   logic [frame_ring_pkg::NUM_CHANNELS-1:0] release_decode;

   // Base pointer register file
   // A configuration strobe rewrites the addressed channel only
   always_ff @(posedge clk) begin
      if (!resetb) begin
         base_pointer <= '0;
      end else if (cfg_write) begin
         base_pointer[cfg_channel] <= cfg_base_pointer;
      end
   end

   // Turn the channel number into a one-hot vector
   // Nothing is selected unless the strobe is present
   always_comb begin
      release_decode = '0;
      if (release_valid) begin
         release_decode[release_channel] = 1'b1;
      end
   end

   // The release pulse reaches the channels one cycle after the strobe
   // Each strobe yields exactly one single-cycle pulse
   always_ff @(posedge clk) begin
      if (!resetb) begin
         release_frame <= '0;
      end else begin
         release_frame <= release_decode;
      end
   end

endmodule

//--- source/frame_release.sv
/*
 * One channel of the frame release path. Counts released frames that
 * still need their header cleared and requests one line write per frame
 */
`timescale 1ns/10ps

module frame_release (
   input  logic                                clk,
   input  logic                                resetb,
   input  frame_ring_pkg::frame_base_pointer_t base_pointer,
   input  logic                                release_frame,
   input  logic                                write_grant,
   output logic                                write_request,
   output frame_ring_pkg::mem_address_t        write_address
);

   // Releases that have not yet been written back to memory
   frame_ring_pkg::pending_t      pending_count;
   frame_ring_pkg::pending_t      pending_count_next;

   // Oldest frame whose header still has to be cleared
   frame_ring_pkg::frame_number_t frame_number_clear;

   // Count up on a release and down on a grant
   // When both arrive together the count holds
   always_comb begin
      pending_count_next = pending_count;
      if (release_frame && !write_grant) begin
         pending_count_next = pending_count + 1'b1;
      end else if (write_grant && !release_frame) begin
         pending_count_next = pending_count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetb) begin
         pending_count <= '0;
      end else begin
         pending_count <= pending_count_next;
      end
   end

   // Every grant writes one header, so move on to the next frame
   // The index wraps naturally at the ring size of 16
   always_ff @(posedge clk) begin
      if (!resetb) begin
         frame_number_clear <= '0;
      end else if (write_grant) begin
         frame_number_clear <= frame_number_clear + 1'b1;
      end
   end

   // Request stays up as long as anything is pending
   assign write_request = (pending_count != '0);

   // Header sits in the first line of the frame, so the chunk bits are zero
   assign write_address = {base_pointer, frame_number_clear,
                           {frame_ring_pkg::LOG_FRAME_CHUNKS{1'b0}}};

endmodule

//--- source/write_arbiter.sv
/*
 * Round-robin write arbiter. Grants one requesting channel per cycle
 * while the memory side has room, and registers the winning line write
 */
`timescale 1ns/10ps

module write_arbiter (
   input  logic                                    clk,
   input  logic                                    resetb,
   input  logic [frame_ring_pkg::NUM_CHANNELS-1:0] write_request,
   input  frame_ring_pkg::mem_address_t [frame_ring_pkg::NUM_CHANNELS-1:0] write_address,
   input  logic                                    mem_almost_full,
   output logic [frame_ring_pkg::NUM_CHANNELS-1:0] write_grant,
   output logic                                    wr_valid,
   output frame_ring_pkg::mem_address_t            wr_address,
   output frame_ring_pkg::line_data_t              wr_data
);

   // Channel that has first claim in the current cycle
   frame_ring_pkg::channel_t rr_pointer;

   // Result of the search in the current cycle
   logic                     grant_found;
   frame_ring_pkg::channel_t grant_channel;

   // Search the requests starting at the round-robin pointer
   // The first requester found wins, and nothing wins under back-pressure
   always_comb begin
      int candidate;

      candidate = 0;
      grant_found = 1'b0;
      grant_channel = rr_pointer;
      write_grant = '0;
      if (!mem_almost_full) begin
         for (int offset = 0; offset < frame_ring_pkg::NUM_CHANNELS; offset++) begin
            candidate = (int'(rr_pointer) + offset) % frame_ring_pkg::NUM_CHANNELS;
            if (!grant_found && write_request[candidate]) begin
               grant_found = 1'b1;
               grant_channel = frame_ring_pkg::channel_t'(candidate);
            end
         end
      end
      // At most one grant bit is ever raised
      if (grant_found) begin
         write_grant[grant_channel] = 1'b1;
      end
   end

   // After a grant the channel following the winner gets first claim
   // Without a grant the pointer stays where it is
   always_ff @(posedge clk) begin
      if (!resetb) begin
         rr_pointer <= '0;
      end else if (grant_found) begin
         rr_pointer <= frame_ring_pkg::channel_t'(
            (int'(grant_channel) + 1) % frame_ring_pkg::NUM_CHANNELS);
      end
   end

   // Memory write strobe follows the grant by one cycle
   always_ff @(posedge clk) begin
      if (!resetb) begin
         wr_valid <= 1'b0;
      end else begin
         wr_valid <= grant_found;
      end
   end

   // Address and data are captured together with the grant
   // They are only looked at while wr_valid is high
   always_ff @(posedge clk) begin
      if (grant_found) begin
         wr_address <= write_address[grant_channel];
         wr_data    <= frame_ring_pkg::RELEASE_LINE;
      end
   end

endmodule

//--- source/frame_release_top.sv
/*
 * Top level of the frame release subsystem. Configuration feeds one
 * release channel per ring and the arbiter merges their header writes
 */
`timescale 1ns/10ps

module frame_release_top (
   input  logic                                clk,
   input  logic                                resetb,
   input  logic                                cfg_write,
   input  frame_ring_pkg::channel_t            cfg_channel,
   input  frame_ring_pkg::frame_base_pointer_t cfg_base_pointer,
   input  logic                                release_valid,
   input  frame_ring_pkg::channel_t            release_channel,
   input  logic                                mem_almost_full,
   output logic                                wr_valid,
   output frame_ring_pkg::mem_address_t        wr_address,
   output frame_ring_pkg::line_data_t          wr_data
);

   // Per-channel release pulses and ring bases from the configuration block
   logic [frame_ring_pkg::NUM_CHANNELS-1:0] release_frame;
   frame_ring_pkg::frame_base_pointer_t [frame_ring_pkg::NUM_CHANNELS-1:0] base_pointer;

   // Request and grant pairs between the channels and the arbiter
   logic [frame_ring_pkg::NUM_CHANNELS-1:0] write_request;
   logic [frame_ring_pkg::NUM_CHANNELS-1:0] write_grant;
   frame_ring_pkg::mem_address_t [frame_ring_pkg::NUM_CHANNELS-1:0] write_address;

   release_config release_config_i (
      .clk              (clk),
      .resetb           (resetb),
      .cfg_write        (cfg_write),
      .cfg_channel      (cfg_channel),
      .cfg_base_pointer (cfg_base_pointer),
      .release_valid    (release_valid),
      .release_channel  (release_channel),
      .release_frame    (release_frame),
      .base_pointer     (base_pointer)
   );

   // One identical release channel per ring
   for (genvar ch = 0; ch < frame_ring_pkg::NUM_CHANNELS; ch++) begin : g_channel
      frame_release frame_release_i (
         .clk           (clk),
         .resetb        (resetb),
         .base_pointer  (base_pointer[ch]),
         .release_frame (release_frame[ch]),
         .write_grant   (write_grant[ch]),
         .write_request (write_request[ch]),
         .write_address (write_address[ch])
      );
   end

   write_arbiter write_arbiter_i (
      .clk             (clk),
      .resetb          (resetb),
      .write_request   (write_request),
      .write_address   (write_address),
      .mem_almost_full (mem_almost_full),
      .write_grant     (write_grant),
      .wr_valid        (wr_valid),
      .wr_address      (wr_address),
      .wr_data         (wr_data)
   );

endmodule

//--- sim/frame_release_tb.sv
/*
 * Testbench for the frame release subsystem. Drives configuration,
 * release strobes and memory back-pressure, and checks every header write
 * against a per-channel model of released and written frames
 */
`timescale 1ns/10ps

module frame_release_tb;

   localparam logic [31:0] LFSR_SEED = 32'h9f5eb322;
   localparam int WRITE_TIMEOUT = 20;
   localparam int DRAIN_TIMEOUT = 400;
   localparam int RANDOM_CYCLES = 300;
   localparam int TOGGLE_CYCLES = 400;
   // Keeps each channel safely below a full ring of unreturned frames
   localparam int MAX_OUTSTANDING = 15;

   logic                                clk;
   logic                                resetb;
   logic                                cfg_write;
   frame_ring_pkg::channel_t            cfg_channel;
   frame_ring_pkg::frame_base_pointer_t cfg_base_pointer;
   logic                                release_valid;
   frame_ring_pkg::channel_t            release_channel;
   logic                                mem_almost_full;
   logic                                wr_valid;
   frame_ring_pkg::mem_address_t        wr_address;
   frame_ring_pkg::line_data_t          wr_data;

   // Model state per channel
   frame_ring_pkg::frame_base_pointer_t cfg_base [frame_ring_pkg::NUM_CHANNELS];
   int released [frame_ring_pkg::NUM_CHANNELS];
   int written  [frame_ring_pkg::NUM_CHANNELS];

   logic [31:0] lfsr_state;
   int          cycle_count;
   int          write_total;
   int          last_write_cycle;
   // Set while any memory write would be an error
   logic        quiet;

   frame_release_top frame_release_top_i (
      .clk              (clk),
      .resetb           (resetb),
      .cfg_write        (cfg_write),
      .cfg_channel      (cfg_channel),
      .cfg_base_pointer (cfg_base_pointer),
      .release_valid    (release_valid),
      .release_channel  (release_channel),
      .mem_almost_full  (mem_almost_full),
      .wr_valid         (wr_valid),
      .wr_address       (wr_address),
      .wr_data          (wr_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   // Prints the fail message and ends the run
   task automatic stop_run();
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic fail_plain(input string reason);
      $display("%s", reason);
      stop_run();
   endtask

   task automatic check_address(input string name,
                                input frame_ring_pkg::mem_address_t actual,
                                input frame_ring_pkg::mem_address_t expected);
      if (actual !== expected) begin
         $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
         stop_run();
      end
   endtask

   task automatic check_data(input string name,
                             input frame_ring_pkg::line_data_t actual,
                             input frame_ring_pkg::line_data_t expected);
      if (actual !== expected) begin
         $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
         stop_run();
      end
   endtask

   task automatic check_count(input string name,
                              input frame_ring_pkg::pending_t actual,
                              input frame_ring_pkg::pending_t expected);
      if (actual !== expected) begin
         $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
         stop_run();
      end
   endtask

   // Fibonacci LFSR with taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic feedback;
      feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], feedback};
   endfunction

   // One LFSR step for every bit taken
   task automatic take_bits(input int count, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value = {value[30:0], lfsr_state[0]};
      end
   endtask

   // Header line of a frame: ring base on top, frame index, chunk offset zero
   function automatic frame_ring_pkg::mem_address_t expected_address(
      input frame_ring_pkg::frame_base_pointer_t base,
      input frame_ring_pkg::frame_number_t       frame);
      frame_ring_pkg::mem_address_t addr;
      addr = frame_ring_pkg::mem_address_t'(base) << 7;
      addr = addr | (frame_ring_pkg::mem_address_t'(frame) << 3);
      return addr;
   endfunction

   // Pending counter inside each DUT channel
   function automatic frame_ring_pkg::pending_t dut_pending(input int ch);
      case (ch)
         0: return frame_release_top_i.g_channel[0].frame_release_i.pending_count;
         1: return frame_release_top_i.g_channel[1].frame_release_i.pending_count;
         2: return frame_release_top_i.g_channel[2].frame_release_i.pending_count;
         3: return frame_release_top_i.g_channel[3].frame_release_i.pending_count;
         default: return '0;
      endcase
   endfunction

   function automatic logic all_written();
      for (int ch = 0; ch < frame_ring_pkg::NUM_CHANNELS; ch++) begin
         if (written[ch] != released[ch]) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   // Compares one observed write with the model and advances the model
   task automatic check_write();
      int ch;
      frame_ring_pkg::frame_base_pointer_t base_field;
      frame_ring_pkg::mem_address_t expected;

      ch = -1;
      base_field = frame_ring_pkg::frame_base_pointer_t'(wr_address >> 7);
      if (quiet) begin
         fail_plain("a memory write appeared while no write was allowed");
      end
      for (int i = 0; i < frame_ring_pkg::NUM_CHANNELS; i++) begin
         if (cfg_base[i] == base_field) begin
            ch = i;
         end
      end
      if (ch < 0) begin
         fail_plain($sformatf("write address 0x%h matches no configured ring", wr_address));
      end
      if (written[ch] >= released[ch]) begin
         fail_plain($sformatf("channel %0d wrote more headers than it released", ch));
      end
      expected = expected_address(cfg_base[ch],
                                  frame_ring_pkg::frame_number_t'(written[ch] % 16));
      check_address("wr_address", wr_address, expected);
      check_data("wr_data", wr_data, 64'h1);
      written[ch]++;
      write_total++;
      last_write_cycle = cycle_count;
   endtask

   // Outputs are registered on the rising edge, so look at them mid-cycle
   always @(negedge clk) begin
      if (resetb === 1'b1 && wr_valid === 1'b1) begin
         check_write();
      end
   end

   // Inputs change a little after each rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_drain(input string what);
      int cycles;
      cycles = 0;
      while (!all_written()) begin
         next_cycle();
         cycles++;
         if (cycles > DRAIN_TIMEOUT) begin
            fail_plain($sformatf("timed out waiting for the %s writes to drain", what));
         end
      end
   endtask

   // DUT pending counters must match what the model still expects
   task automatic check_pending_counts();
      for (int ch = 0; ch < frame_ring_pkg::NUM_CHANNELS; ch++) begin
         check_count($sformatf("pending_count[%0d]", ch), dut_pending(ch),
                     frame_ring_pkg::pending_t'(released[ch] - written[ch]));
      end
   endtask

   // Distinct bases, since the low two bits are the channel number
   task automatic configure_bases();
      logic [31:0] bits;
      for (int ch = 0; ch < frame_ring_pkg::NUM_CHANNELS; ch++) begin
         take_bits(23, bits);
         next_cycle();
         cfg_write = 1'b1;
         cfg_channel = frame_ring_pkg::channel_t'(ch);
         cfg_base_pointer = {bits[22:0], 2'(ch)};
         cfg_base[ch] = cfg_base_pointer;
      end
      next_cycle();
      cfg_write = 1'b0;
   endtask

   // One release on channel 0, whose write must follow three cycles later
   task automatic single_release_latency();
      int start_cycle;
      int start_total;
      int cycles;

      start_total = write_total;
      next_cycle();
      release_valid = 1'b1;
      release_channel = '0;
      released[0]++;
      start_cycle = cycle_count;
      next_cycle();
      release_valid = 1'b0;
      cycles = 0;
      while (write_total == start_total) begin
         next_cycle();
         cycles++;
         if (cycles > WRITE_TIMEOUT) begin
            fail_plain("timed out waiting for the write of a single release");
         end
      end
      if (last_write_cycle - start_cycle != 3) begin
         fail_plain($sformatf("release to write latency was %0d cycles instead of 3",
                              last_write_cycle - start_cycle));
      end
      repeat (10) next_cycle();
      if (write_total != start_total + 1) begin
         fail_plain($sformatf("one release produced %0d writes", write_total - start_total));
      end
   endtask

   // Back-to-back releases on a single channel
   task automatic release_batch(input int ch, input int count);
      for (int i = 0; i < count; i++) begin
         next_cycle();
         release_valid = 1'b1;
         release_channel = frame_ring_pkg::channel_t'(ch);
         released[ch]++;
      end
      next_cycle();
      release_valid = 1'b0;
   endtask

   // Random releases, optionally with random back-pressure runs
   task automatic random_traffic(input int cycles, input logic toggle_full);
      logic [31:0] bits;
      int ch;
      for (int i = 0; i < cycles; i++) begin
         next_cycle();
         release_valid = 1'b0;
         if (toggle_full) begin
            take_bits(3, bits);
            if (bits[2:0] == 3'd0) begin
               mem_almost_full = ~mem_almost_full;
            end
         end
         take_bits(2, bits);
         if (bits[1:0] != 2'd0) begin
            take_bits(2, bits);
            ch = int'(bits[1:0]);
            if (released[ch] - written[ch] < MAX_OUTSTANDING) begin
               release_valid = 1'b1;
               release_channel = frame_ring_pkg::channel_t'(ch);
               released[ch]++;
            end
         end
      end
      next_cycle();
      release_valid = 1'b0;
      mem_almost_full = 1'b0;
   endtask

   // Releases pile up under back-pressure and drain once it lifts
   task automatic back_pressure_test();
      next_cycle();
      mem_almost_full = 1'b1;
      quiet = 1'b1;
      for (int i = 0; i < 10; i++) begin
         next_cycle();
         release_valid = 1'b1;
         release_channel = frame_ring_pkg::channel_t'(i % frame_ring_pkg::NUM_CHANNELS);
         released[i % frame_ring_pkg::NUM_CHANNELS]++;
      end
      next_cycle();
      release_valid = 1'b0;
      repeat (8) next_cycle();
      check_pending_counts();
      mem_almost_full = 1'b0;
      quiet = 1'b0;
      wait_drain("back-pressure");
      check_pending_counts();
   endtask

   initial begin
      resetb = 1'b0;
      cfg_write = 1'b0;
      cfg_channel = '0;
      cfg_base_pointer = '0;
      release_valid = 1'b0;
      release_channel = '0;
      mem_almost_full = 1'b0;
      lfsr_state = LFSR_SEED;
      cycle_count = 0;
      write_total = 0;
      last_write_cycle = 0;
      quiet = 1'b0;
      for (int ch = 0; ch < frame_ring_pkg::NUM_CHANNELS; ch++) begin
         cfg_base[ch] = '0;
         released[ch] = 0;
         written[ch] = 0;
      end

      repeat (16) @(posedge clk);
      #1;
      resetb = 1'b1;

      // Idle after reset, no write may appear
      quiet = 1'b1;
      repeat (20) next_cycle();
      quiet = 1'b0;

      configure_bases();
      repeat (4) next_cycle();
      single_release_latency();

      // Twenty frames on channel 1 wrap the ring index after 15
      release_batch(1, 12);
      wait_drain("first batch");
      release_batch(1, 8);
      wait_drain("second batch");
      check_pending_counts();

      random_traffic(RANDOM_CYCLES, 1'b0);
      wait_drain("random release");
      check_pending_counts();

      back_pressure_test();

      random_traffic(TOGGLE_CYCLES, 1'b1);
      wait_drain("random back-pressure");
      check_pending_counts();

      $display("TESTS PASSED");
      $finish;
   end

endmodule

//--- build.f
source/frame_ring_pkg.sv
source/release_config.sv
source/frame_release.sv
source/write_arbiter.sv
source/frame_release_top.sv
sim/frame_release_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the frame release testbench with Verilator and run it
# A $fatal in the testbench gives a nonzero exit status
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module frame_release_tb \
   -f build.f -o frame_release_sim &&
./obj_dir/frame_release_sim ||
{ echo "frame release simulation did not complete cleanly"; exit 1; }
